/* dma_top.f */
src/dma_pkg.sv
src/dma_ctrl.sv
src/dma_bus_master.sv
src/dma_desc_regs.sv
src/dma_status_gen.sv
src/dma_top.sv
verif/dma_assertions.sv
verif/dma_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module dma_tb -f dma_top.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/Vdma_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
   exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* src/dma_bus_master.sv */
// Wishbone master burst unit; runs one 4-beat burst per start pulse, advancing on each ack
`timescale 1ns/1ps
`default_nettype none

module dma_bus_master (
   input  wire                  wb_clk_i,
   input  wire                  wb_rst_i,
   input  wire                  burst_start_i,
   input  wire dma_pkg::daddr_t burst_base_i,
   input  wire                  burst_we_i,
   input  wire                  ack_i,
   input  wire dma_pkg::word_t  wdat_i,
   output dma_pkg::wb_req_t     wb_o,
   output dma_pkg::beat_t       beat_o,
   output logic                 burst_done_o
);
   import dma_pkg::*;

   logic  cyc_q;
   logic  stb_q;
   logic  we_q;
   beat_t beat_q;
   word_t adr_q;
   logic  beat_ack; // current beat accepted

   assign beat_ack     = cyc_q && stb_q && ack_i;
   assign burst_done_o = beat_ack && (beat_q == 2'd3);
   assign beat_o       = beat_q;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         cyc_q  <= 1'b0;
         stb_q  <= 1'b0;
         we_q   <= 1'b0;
         beat_q <= '0;
      end else if (burst_start_i) begin
         cyc_q  <= 1'b1;
         stb_q  <= 1'b1;
         we_q   <= burst_we_i;
         beat_q <= '0;
      end else begin
         if (beat_ack) begin
            beat_q <= beat_q + 2'd1; // wraps to 0 after beat 3
         end
         if (burst_done_o) begin
            cyc_q <= 1'b0;
            stb_q <= 1'b0;
            we_q  <= 1'b0;
         end
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (burst_start_i) begin
         adr_q <= {burst_base_i, 3'b000};
      end else if (beat_ack) begin
         adr_q <= adr_q + 32'd4; // next word
      end
   end

   assign wb_o = '{cyc: cyc_q,
                   stb: stb_q,
                   we:  we_q,
                   sel: {4{cyc_q}}, // full words only
                   adr: adr_q,
                   dat: wdat_i};

endmodule

`default_nettype wire

/* src/dma_ctrl.sv */
// job sequencer FSM; walks the descriptor chain through fetch, dispatch, wait, writeback, commit
`timescale 1ns/1ps
`default_nettype none

module dma_ctrl (
   input  wire                  wb_clk_i,
   input  wire                  wb_rst_i,
   input  wire                  enable_i,
   input  wire                  ndar_dirty_i,
   input  wire dma_pkg::daddr_t ndar_i,
   input  wire                  burst_done_i,
   input  wire                  eng_done_i,
   input  wire dma_pkg::desc_t  desc_i,
   input  wire dma_pkg::daddr_t cdar_i,
   output logic                 burst_start_o,
   output dma_pkg::daddr_t      burst_base_o,
   output logic                 burst_we_o,
   output logic                 capture_o,
   output logic                 eng_start_o,
   output logic                 commit_o,
   output logic                 ndar_dirty_clear_o,
   output logic                 busy_o,
   output dma_pkg::daddr_t      dar_o
);
   import dma_pkg::*;

   ctrl_state_t state_q;
   ctrl_state_t state_d;
   logic        new_chain; // software kicked a new chain
   logic        fetch_go;  // read burst launched this cycle
   logic        wb_go;     // status burst launched this cycle
   logic        dc_wb;
   logic        dc_chain;

   assign dc_wb     = desc_i.dc[DC_WB_BIT];
   assign dc_chain  = desc_i.dc[DC_CHAIN_BIT];
   assign new_chain = (state_q == S_IDLE) && enable_i && ndar_dirty_i;
   assign fetch_go  = new_chain || ((state_q == S_COMMIT) && dc_chain);
   assign wb_go     = (state_q == S_WAIT) && eng_done_i && dc_wb;

   assign burst_start_o = fetch_go || wb_go;
   assign burst_we_o    = (state_q == S_WAIT); // only the status burst writes
   assign capture_o     = fetch_go || (state_q == S_FETCH);
   assign eng_start_o   = (state_q == S_DISPATCH);
   assign commit_o      = (state_q == S_COMMIT);
   assign busy_o        = (state_q != S_IDLE);

   always_comb begin
      case (state_q)
         S_WAIT:   burst_base_o = desc_i.ctl_adr;   // status block
         S_COMMIT: burst_base_o = desc_i.next_desc; // chained fetch
         default:  burst_base_o = ndar_i;
      endcase
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         S_IDLE: begin
            if (new_chain) begin
               state_d = S_FETCH;
            end
         end
         S_FETCH: begin
            if (burst_done_i) begin
               state_d = S_DISPATCH;
            end
         end
         S_DISPATCH: begin
            state_d = S_WAIT; // one-cycle engine start
         end
         S_WAIT: begin
            if (eng_done_i) begin
               state_d = dc_wb ? S_STATUS : S_COMMIT;
            end
         end
         S_STATUS: begin
            if (burst_done_i) begin
               state_d = S_COMMIT;
            end
         end
         S_COMMIT: begin
            state_d = dc_chain ? S_FETCH : S_IDLE;
         end
         default: begin
            state_d = S_IDLE;
         end
      endcase
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state_q            <= S_IDLE;
         ndar_dirty_clear_o <= 1'b0;
         dar_o              <= '0;
      end else begin
         state_q            <= state_d;
         ndar_dirty_clear_o <= new_chain; // ack the dirty flag once
         if (commit_o) begin
            dar_o <= cdar_i; // last finished descriptor
         end
      end
   end

endmodule

`default_nettype wire

/* src/dma_desc_regs.sv */
// descriptor holding registers; loaded beat by beat from the fetch burst read data
`timescale 1ns/1ps
`default_nettype none

module dma_desc_regs (
   input  wire                  wb_clk_i,
   input  wire                  wb_rst_i,
   input  wire                  capture_i,
   input  wire                  burst_start_i,
   input  wire dma_pkg::daddr_t burst_base_i,
   input  wire dma_pkg::beat_t  beat_i,
   input  wire                  ack_i,
   input  wire dma_pkg::word_t  dat_i,
   output dma_pkg::desc_t       desc_o,
   output dma_pkg::daddr_t      cdar_o
);

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         desc_o <= '0;
         cdar_o <= '0;
      end else if (capture_i) begin
         if (burst_start_i) begin
            cdar_o <= burst_base_i; // address of the descriptor being read
         end else if (ack_i) begin
            case (beat_i)
               2'd0:    desc_o.next_desc <= dat_i[31:3];
               2'd1:    desc_o.ctl_adr   <= dat_i[31:3];
               2'd2:    desc_o.dc        <= dat_i[23:0];
               default: ; // beat 3 reserved
            endcase
         end
      end
   end

endmodule

`default_nettype wire

/* src/dma_pkg.sv */
// shared widths, bus and descriptor structs and FSM states; imported by the DMA RTL and testbench
`default_nettype none

package dma_pkg;

   typedef logic [31:0] word_t;   // one bus data word
   typedef logic [28:0] daddr_t;  // byte address bits 31:3
   typedef logic [23:0] dcount_t; // descriptor control word
   typedef logic [1:0]  beat_t;   // beat within a 4-beat burst
   typedef logic [15:0] ocnt_t;   // engine output count

   // control word flag positions
   localparam int DC_WB_BIT    = 7;  // status writeback
   localparam int DC_CHAIN_BIT = 14; // follow next_desc
   localparam int DC_INT_BIT   = 15; // interrupt on commit

   // master side of the Wishbone port, 71 bits
   typedef struct packed {
      logic       cyc;
      logic       stb;
      logic       we;
      logic [3:0] sel;
      word_t      adr; // byte address
      word_t      dat;
   } wb_req_t;

   // fetched descriptor, 82 bits
   typedef struct packed {
      daddr_t  next_desc;
      daddr_t  ctl_adr;
      dcount_t dc;
   } desc_t;

   typedef enum logic [2:0] {
      S_IDLE,
      S_FETCH,
      S_DISPATCH,
      S_WAIT,
      S_STATUS,
      S_COMMIT
   } ctrl_state_t;

endpackage

`default_nettype wire

/* src/dma_status_gen.sv */
// job cycle timer, status writeback word mux and interrupt flag for the DMA controller
`timescale 1ns/1ps
`default_nettype none

module dma_status_gen (
   input  wire                   wb_clk_i,
   input  wire                   wb_rst_i,
   input  wire                   eng_start_i,
   input  wire                   eng_done_i,
   input  wire dma_pkg::beat_t   beat_i,
   input  wire dma_pkg::dcount_t dc_i,
   input  wire dma_pkg::ocnt_t   ocnt_i,
   input  wire                   commit_i,
   input  wire                   int_clear_i,
   output dma_pkg::word_t        wdat_o,
   output logic                  int_o
);
   import dma_pkg::*;

   logic  run_q;
   word_t cyc_cnt_q; // edges from engine start to done

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         run_q <= 1'b0;
         int_o <= 1'b0;
      end else begin
         if (eng_start_i) begin
            run_q <= 1'b1;
         end else if (eng_done_i) begin
            run_q <= 1'b0;
         end
         // clear beats a coincident set
         if (int_clear_i) begin
            int_o <= 1'b0;
         end else if (commit_i && dc_i[DC_INT_BIT]) begin
            int_o <= 1'b1;
         end
      end
   end

   // done edge still counts, then the value holds
   always_ff @(posedge wb_clk_i) begin
      if (eng_start_i) begin
         cyc_cnt_q <= '0;
      end else if (run_q) begin
         cyc_cnt_q <= cyc_cnt_q + 32'd1;
      end
   end

   always_comb begin
      case (beat_i)
         2'd0:    wdat_o = {13'd0, ocnt_i, 3'b000}; // byte count
         2'd1:    wdat_o = '0;
         2'd2:    wdat_o = cyc_cnt_q;
         default: wdat_o = {8'd0, dc_i};
      endcase
   end

endmodule

`default_nettype wire

/* src/dma_top.sv */
// DMA controller top level; wires the FSM, bus master, descriptor and status blocks
`timescale 1ns/1ps
`default_nettype none

module dma_top (
   input  wire                   wb_clk_i,
   input  wire                   wb_rst_i,
   input  wire                   enable_i,
   input  wire                   ndar_dirty_i,
   input  wire dma_pkg::daddr_t  ndar_i,
   input  wire                   int_clear_i,
   input  wire                   ack_i,
   input  wire dma_pkg::word_t   dat_i,
   input  wire                   eng_done_i,
   input  wire dma_pkg::ocnt_t   ocnt_i,
   output dma_pkg::wb_req_t      wb_o,
   output logic                  ndar_dirty_clear_o,
   output logic                  busy_o,
   output dma_pkg::daddr_t       dar_o,
   output logic                  int_o,
   output logic                  eng_start_o,
   output dma_pkg::dcount_t      eng_dc_o
);
   import dma_pkg::*;

   logic   burst_start;
   daddr_t burst_base;
   logic   burst_we;
   logic   burst_done;
   logic   capture;
   logic   commit;
   beat_t  beat;
   desc_t  desc;
   daddr_t cdar;
   word_t  wdat;

   assign eng_dc_o = desc.dc; // held for the whole job

   dma_ctrl u_ctrl (
      .wb_clk_i           (wb_clk_i),
      .wb_rst_i           (wb_rst_i),
      .enable_i           (enable_i),
      .ndar_dirty_i       (ndar_dirty_i),
      .ndar_i             (ndar_i),
      .burst_done_i       (burst_done),
      .eng_done_i         (eng_done_i),
      .desc_i             (desc),
      .cdar_i             (cdar),
      .burst_start_o      (burst_start),
      .burst_base_o       (burst_base),
      .burst_we_o         (burst_we),
      .capture_o          (capture),
      .eng_start_o        (eng_start_o),
      .commit_o           (commit),
      .ndar_dirty_clear_o (ndar_dirty_clear_o),
      .busy_o             (busy_o),
      .dar_o              (dar_o)
   );

   dma_bus_master u_bus_master (
      .wb_clk_i      (wb_clk_i),
      .wb_rst_i      (wb_rst_i),
      .burst_start_i (burst_start),
      .burst_base_i  (burst_base),
      .burst_we_i    (burst_we),
      .ack_i         (ack_i),
      .wdat_i        (wdat),
      .wb_o          (wb_o),
      .beat_o        (beat),
      .burst_done_o  (burst_done)
   );

   dma_desc_regs u_desc_regs (
      .wb_clk_i      (wb_clk_i),
      .wb_rst_i      (wb_rst_i),
      .capture_i     (capture),
      .burst_start_i (burst_start),
      .burst_base_i  (burst_base),
      .beat_i        (beat),
      .ack_i         (ack_i),
      .dat_i         (dat_i),
      .desc_o        (desc),
      .cdar_o        (cdar)
   );

   dma_status_gen u_status_gen (
      .wb_clk_i    (wb_clk_i),
      .wb_rst_i    (wb_rst_i),
      .eng_start_i (eng_start_o),
      .eng_done_i  (eng_done_i),
      .beat_i      (beat),
      .dc_i        (desc.dc),
      .ocnt_i      (ocnt_i),
      .commit_i    (commit),
      .int_clear_i (int_clear_i),
      .wdat_o      (wdat),
      .int_o       (int_o)
   );

endmodule

`default_nettype wire

/* verif/dma_assertions.sv */
// concurrent checks on the Wishbone master port and engine start strobe; bound into the DMA top level
`timescale 1ns/1ps
`default_nettype none

module dma_assertions (
   input wire                   wb_clk_i,
   input wire                   wb_rst_i,
   input wire dma_pkg::wb_req_t wb_i,
   input wire                   ack_i,
   input wire                   eng_start_i
);

   a_stb_in_cyc: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      wb_i.stb |-> wb_i.cyc)
      else $error("wishbone stb high without cyc");

   // beat waits for its ack
   a_adr_hold: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      (wb_i.stb && !ack_i) |=> $stable(wb_i.adr))
      else $error("wishbone address moved during a wait state");

   a_start_pulse: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      eng_start_i |=> !eng_start_i)
      else $error("engine start held longer than one cycle");

endmodule

`default_nettype wire

/* verif/dma_tb.sv */
// self-checking testbench for the DMA controller; random chains against memory and engine models
`timescale 1ns/1ps
`default_nettype none

module dma_tb;
   import dma_pkg::*;

   localparam int    CLK_PERIOD   = 4;
   localparam int    RESET_CYCLES = 3;
   localparam int    NUM_CHAINS   = 3;
   localparam int    MAX_DESC     = 5;
   localparam int    WATCHDOG_NS  =
      (RESET_CYCLES + NUM_CHAINS * (MAX_DESC * 200 + 20)) * CLK_PERIOD;
   localparam word_t LFSR_TAPS    = 32'h80200003;

   logic    wb_clk_i;
   logic    wb_rst_i;
   logic    enable_i;
   logic    ndar_dirty_i;
   daddr_t  ndar_i;
   logic    int_clear_i;
   logic    ack_i;
   word_t   dat_i;
   logic    eng_done_i;
   ocnt_t   ocnt_i;
   wb_req_t wb_o;
   logic    ndar_dirty_clear_o;
   logic    busy_o;
   daddr_t  dar_o;
   logic    int_o;
   logic    eng_start_o;
   dcount_t eng_dc_o;

   word_t   lfsr_q = 32'h5ccbfe0d;
   word_t   mem [word_t];  // written words by byte address
   word_t   desc_adr [$];
   word_t   ctl_adr [$];
   dcount_t dc_tab [$];
   ocnt_t   exp_ocnt [$];
   int      exp_cnt [$];   // start-to-done edges per job
   int      n_desc;
   int      fj;            // descriptors fetched
   int      dj;            // jobs dispatched
   int      rd_beat;
   int      wr_beat;
   int      wr_words;
   int      delay;
   bit      fail_seen;
   bit      pass_seen;

   dma_top u_dma_top (.*);

   bind dma_top dma_assertions u_dma_assertions (
      .wb_clk_i    (wb_clk_i),
      .wb_rst_i    (wb_rst_i),
      .wb_i        (wb_o),
      .ack_i       (ack_i),
      .eng_start_i (eng_start_o)
   );

   initial begin
      wb_clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;
   end

   // galois lfsr, one step per bit taken
   function automatic word_t rand_bits(int n);
      word_t r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsr_q[0]};
         lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ LFSR_TAPS) : (lfsr_q >> 1);
      end
      return r;
   endfunction

   function automatic word_t fill_word(word_t a);
      return (a ^ 32'h5a3c0000) + {a[15:0], a[31:16]};
   endfunction

   function automatic word_t mem_read(word_t a);
      if (mem.exists(a)) begin
         return mem[a];
      end
      return fill_word(a);
   endfunction

   // status block layout of one job
   function automatic word_t status_word(int beat, int job);
      case (beat)
         0:       return {13'd0, exp_ocnt[job], 3'b000};
         1:       return 32'd0;
         2:       return word_t'(exp_cnt[job]);
         default: return {8'd0, dc_tab[job]};
      endcase
   endfunction

   function automatic bit int_expected(int jobs);
      bit any;
      any = 1'b0;
      for (int k = 0; k < jobs; k++) begin
         any |= dc_tab[k][DC_INT_BIT];
      end
      return any;
   endfunction

   task automatic report_mismatch(string name, word_t got, word_t exp);
      fail_seen = 1'b1;
      $display("CHECK FAILED time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "stopped at first mismatch");
   endtask

   task automatic report_error(string what);
      fail_seen = 1'b1;
      $display("ERROR time=%0t %s", $time, what);
      $display("TEST FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_word(string name, word_t got, word_t exp);
      assert (got === exp) else report_mismatch(name, got, exp);
   endtask

   // wishbone slave, random ack per cycle
   always @(posedge wb_clk_i) begin
      #1;
      ack_i = (rand_bits(1) != 0) && wb_o.stb;
      dat_i = wb_o.stb ? mem_read(wb_o.adr) : 32'd0;
   end

   // copy engine, done after 1 to 8 cycles
   always @(negedge wb_clk_i) begin
      if (!wb_rst_i && eng_start_o) begin
         delay = 1 + int'(rand_bits(3));
         repeat (delay) @(posedge wb_clk_i);
         #1;
         ocnt_i = ocnt_t'(rand_bits(16));
         exp_ocnt.push_back(ocnt_i);
         exp_cnt.push_back(delay);
         eng_done_i = 1'b1;
         @(posedge wb_clk_i);
         #1;
         eng_done_i = 1'b0;
      end
   end

   // bus and engine monitor, mid-cycle
   always @(negedge wb_clk_i) begin
      if (!wb_rst_i && wb_o.cyc && wb_o.stb && ack_i) begin
         check_word("wb_o.sel", {28'd0, wb_o.sel}, 32'h0000000f);
      end
      if (!wb_rst_i && wb_o.cyc && wb_o.stb && ack_i && !wb_o.we) begin
         assert (fj < n_desc) else report_error("read burst past the end of the chain");
         check_word("wb_o.adr", wb_o.adr, desc_adr[fj] + 4 * rd_beat);
         if (rd_beat == 0 && fj > 0) begin
            check_word("dar_o", {dar_o, 3'b000}, desc_adr[fj - 1]); // previous job committed
            check_word("int_o", {31'd0, int_o}, {31'd0, int_expected(fj)});
         end
         if (rd_beat == 3) begin
            rd_beat = 0;
            fj++;
         end else begin
            rd_beat++;
         end
      end
      if (!wb_rst_i && wb_o.cyc && wb_o.stb && ack_i && wb_o.we) begin
         assert (dj > 0 && dc_tab[dj - 1][DC_WB_BIT])
            else report_error("status write for a job without writeback");
         check_word("wb_o.adr", wb_o.adr, ctl_adr[dj - 1] + 4 * wr_beat);
         check_word("wb_o.dat", wb_o.dat, status_word(wr_beat, dj - 1));
         mem[wb_o.adr] = wb_o.dat;
         wr_beat = (wr_beat == 3) ? 0 : wr_beat + 1;
         wr_words++;
      end
      if (!wb_rst_i && eng_start_o) begin
         assert (dj < n_desc) else report_error("engine start with no descriptor left");
         check_word("eng_dc_o", {8'd0, eng_dc_o}, {8'd0, dc_tab[dj]});
         dj++;
      end
   end

   task automatic run_chain(bit allow_int);
      dcount_t dc;
      bit      any_int;
      int      wb_jobs;
      mem.delete();
      desc_adr.delete();
      ctl_adr.delete();
      dc_tab.delete();
      exp_ocnt.delete();
      exp_cnt.delete();
      n_desc   = 2 + int'(rand_bits(2));
      fj       = 0;
      dj       = 0;
      rd_beat  = 0;
      wr_beat  = 0;
      wr_words = 0;
      any_int  = 1'b0;
      wb_jobs  = 0;
      for (int k = 0; k < n_desc; k++) begin
         desc_adr.push_back(word_t'((k * 32 + int'(rand_bits(4))) * 16)); // slot in region k
         ctl_adr.push_back(word_t'((k * 32 + 16 + int'(rand_bits(4))) * 16));
      end
      for (int k = 0; k < n_desc; k++) begin
         dc = dcount_t'(rand_bits(24));
         dc[DC_CHAIN_BIT] = (k < n_desc - 1);
         if (!allow_int) begin
            dc[DC_INT_BIT] = 1'b0;
         end
         dc_tab.push_back(dc);
         any_int |= dc[DC_INT_BIT];
         if (dc[DC_WB_BIT]) begin
            wb_jobs++;
         end
         mem[desc_adr[k]]     = (k < n_desc - 1) ? desc_adr[k + 1] : 32'd0;
         mem[desc_adr[k] + 4] = ctl_adr[k];
         mem[desc_adr[k] + 8] = {8'd0, dc};
      end
      @(posedge wb_clk_i);
      #1;
      ndar_i       = desc_adr[0][31:3];
      enable_i     = 1'b1;
      ndar_dirty_i = 1'b1;
      @(negedge wb_clk_i);
      while (!ndar_dirty_clear_o) @(negedge wb_clk_i);
      @(posedge wb_clk_i);
      #1;
      ndar_dirty_i = 1'b0;
      @(negedge wb_clk_i);
      check_word("ndar_dirty_clear_o", {31'd0, ndar_dirty_clear_o}, 32'd0); // single pulse
      while (busy_o) @(negedge wb_clk_i);
      check_word("descriptors fetched", fj, n_desc);
      check_word("eng_start_o pulses", dj, n_desc);
      check_word("status words written", wr_words, 4 * wb_jobs);
      check_word("dar_o", {dar_o, 3'b000}, desc_adr[n_desc - 1]);
      for (int k = 0; k < n_desc; k++) begin
         for (int b = 0; b < 4; b++) begin
            check_word("status block in memory", mem_read(ctl_adr[k] + 4 * b),
                       dc_tab[k][DC_WB_BIT] ? status_word(b, k) : fill_word(ctl_adr[k] + 4 * b));
         end
      end
      repeat (3) @(negedge wb_clk_i);
      check_word("int_o", {31'd0, int_o}, {31'd0, any_int}); // held until cleared
      @(posedge wb_clk_i);
      #1;
      int_clear_i = 1'b1;
      @(posedge wb_clk_i);
      #1;
      int_clear_i = 1'b0;
      @(negedge wb_clk_i);
      check_word("int_o", {31'd0, int_o}, 32'd0);
   endtask

   initial begin
      wb_rst_i     = 1'b1;
      enable_i     = 1'b0;
      ndar_dirty_i = 1'b0;
      ndar_i       = '0;
      int_clear_i  = 1'b0;
      ack_i        = 1'b0;
      dat_i        = '0;
      eng_done_i   = 1'b0;
      ocnt_i       = '0;
      repeat (RESET_CYCLES - 1) @(posedge wb_clk_i);
      @(negedge wb_clk_i);
      check_word("wb_o.cyc", {31'd0, wb_o.cyc}, 32'd0);
      check_word("wb_o.stb", {31'd0, wb_o.stb}, 32'd0);
      check_word("eng_start_o", {31'd0, eng_start_o}, 32'd0);
      check_word("int_o", {31'd0, int_o}, 32'd0);
      check_word("ndar_dirty_clear_o", {31'd0, ndar_dirty_clear_o}, 32'd0);
      check_word("busy_o", {31'd0, busy_o}, 32'd0);
      check_word("dar_o", {3'b000, dar_o}, 32'd0);
      @(posedge wb_clk_i);
      #1;
      wb_rst_i = 1'b0;
      for (int c = 0; c < NUM_CHAINS; c++) begin
         run_chain(c != 1); // second chain has no interrupt requests
      end
      if (fail_seen) begin
         $display("TEST FAIL");
      end else begin
         pass_seen = 1'b1;
         $display("TEST PASS");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      report_error("watchdog expired before all chains finished");
   end

   final begin
      if (!pass_seen && !fail_seen) begin
         $display("TEST FAIL"); // run stopped by a bound assertion
      end
   end

endmodule

`default_nettype wire
